// File: rtl/icache_pkg.sv
// -------------------
// Geometry, address fields, entry types and FSM states of the
// instruction cache. Each RTL module imports what it needs.
// -------------------
package icache_pkg;

    localparam int ICACHE_N_WAY = 2;
    localparam int ICACHE_N_SET = 16;

    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 4;                        // 16-byte lines.
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int LINE_W   = 128;
    localparam int WORD_W   = 32;
    localparam int NC_BIT   = 31;                       // Set means non-cacheable.
    localparam int CNT_W    = 16;

    typedef logic [TAG_W-1:0]  tag_entry_t;
    typedef logic [LINE_W-1:0] line_entry_t;

    typedef enum logic [2:0] {
        READ   = 3'd1,
        MISS   = 3'd2,
        REPLAY = 3'd3,
        KILL   = 3'd4,
        FLUSH  = 3'd5
    } ictrl_state_t;

    // Register addresses of the configuration block
    localparam logic [1:0] CSR_CTRL     = 2'd0;
    localparam logic [1:0] CSR_STATUS   = 2'd1;
    localparam logic [1:0] CSR_MISS_CNT = 2'd2;
    localparam logic [1:0] CSR_KILL_CNT = 2'd3;

endpackage

// File: rtl/icache_way_ram.sv
// -------------------
// Storage for one cache way, one entry per set. Read data is
// registered. The entry type selects tag or line payload.
// -------------------
module icache_way_ram #(
    parameter type entry_t = icache_pkg::tag_entry_t
) (
    input  logic                           clk_i,
    input  logic                           rd_en_i,
    input  logic                           wr_en_i,
    input  logic [icache_pkg::INDEX_W-1:0] index_i,
    input  entry_t                         wdata_i,
    output entry_t                         rdata_o
);
    import icache_pkg::*;

    entry_t mem_q [ICACHE_N_SET];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[index_i] <= wdata_i;
        end
        if (rd_en_i) begin
            rdata_o <= mem_q[index_i];                  // Ready in the compare stage.
        end
    end

endmodule

// File: rtl/icache_lookup.sv
// -------------------
// Lookup datapath: request register, valid bits, tag compare,
// round-robin victims, flush sweep, fill buffer and word select.
// Steered by icache_ctrl.
// -------------------
module icache_lookup (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                ireq_valid_i,
    input  logic [icache_pkg::ADDR_W-1:0]       ireq_addr_i,
    input  logic                                cache_enable_i,
    input  logic                                cmp_enable_i,
    input  logic                                cache_wr_ena_i,
    input  logic                                fill_capture_i,
    input  logic                                replay_valid_i,
    input  logic                                flush_en_i,
    input  logic [icache_pkg::LINE_W-1:0]       ifill_resp_data_i,
    input  icache_pkg::tag_entry_t              tag_rdata_i [icache_pkg::ICACHE_N_WAY],
    input  icache_pkg::line_entry_t             line_rdata_i [icache_pkg::ICACHE_N_WAY],
    output logic                                ram_rd_en_o,
    output logic [icache_pkg::ICACHE_N_WAY-1:0] ram_wr_en_o,
    output logic [icache_pkg::INDEX_W-1:0]      ram_index_o,
    output icache_pkg::tag_entry_t              tag_wdata_o,
    output icache_pkg::line_entry_t             line_wdata_o,
    output logic                                req_pending_o,
    output logic [icache_pkg::ICACHE_N_WAY-1:0] cline_hit_o,
    output logic                                paddr_is_nc_o,
    output logic                                flush_done_o,
    output logic [icache_pkg::ADDR_W-1:0]       ifill_addr_o,
    output logic [icache_pkg::WORD_W-1:0]       iresp_data_o
);
    import icache_pkg::*;

    logic [ADDR_W-1:0]       addr_q;
    logic                    req_q;
    logic [INDEX_W-1:0]      idx_q;
    tag_entry_t              tag_q;
    logic [ICACHE_N_WAY-1:0] valid_q [ICACHE_N_SET];
    logic [ICACHE_N_SET-1:0] victim_q;               // Next way to replace, per set.
    logic [INDEX_W-1:0]      flush_cnt_q;
    line_entry_t             fill_buf_q;
    line_entry_t             sel_line;

    assign idx_q = addr_q[OFFSET_W +: INDEX_W];
    assign tag_q = addr_q[ADDR_W-1 -: TAG_W];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            req_q <= 1'b0;
        end else begin
            req_q <= ireq_valid_i;                      // Compare stage lasts one cycle.
        end
    end

    // Address is held through MISS and REPLAY
    always_ff @(posedge clk_i) begin
        if (ireq_valid_i) begin
            addr_q <= ireq_addr_i;
        end
        if (fill_capture_i) begin
            fill_buf_q <= ifill_resp_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q     <= '{default: '0};
            victim_q    <= '0;
            flush_cnt_q <= '0;
        end else if (flush_en_i) begin
            valid_q[flush_cnt_q]  <= '0;                // One set per cycle.
            victim_q[flush_cnt_q] <= 1'b0;
            flush_cnt_q           <= flush_cnt_q + 1'b1;
        end else if (cache_wr_ena_i) begin
            valid_q[idx_q][victim_q[idx_q]] <= 1'b1;
            victim_q[idx_q]                 <= ~victim_q[idx_q];
        end
    end

    assign flush_done_o = flush_en_i && (flush_cnt_q == INDEX_W'(ICACHE_N_SET - 1));

    assign ram_rd_en_o  = ireq_valid_i;
    assign ram_index_o  = flush_en_i     ? flush_cnt_q :
                          cache_wr_ena_i ? idx_q       :
                                           ireq_addr_i[OFFSET_W +: INDEX_W];
    assign tag_wdata_o  = flush_en_i ? '0 : tag_q;      // Sweep also scrubs the tags.
    assign line_wdata_o = ifill_resp_data_i;

    always_comb begin
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
            ram_wr_en_o[w] = flush_en_i || (cache_wr_ena_i && (victim_q[idx_q] == 1'(w)));
        end
    end

    assign req_pending_o = req_q;
    assign paddr_is_nc_o = addr_q[NC_BIT];
    assign ifill_addr_o  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // Hit vector and response line source
    always_comb begin
        sel_line = line_rdata_i[0];
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
            cline_hit_o[w] = req_q && cmp_enable_i && cache_enable_i && !paddr_is_nc_o
                             && valid_q[idx_q][w] && (tag_rdata_i[w] == tag_q);
            if (cline_hit_o[w]) begin
                sel_line = line_rdata_i[w];
            end
        end
        if (replay_valid_i) begin
            sel_line = fill_buf_q;                      // Word comes from the fill.
        end
    end

    assign iresp_data_o = sel_line[addr_q[3:2]*WORD_W +: WORD_W];

endmodule

// File: rtl/icache_ctrl.sv
// -------------------
// Cache controller FSM. Decides hit, miss, kill, replay and
// flush, and drives the datapath enables and core strobes.
// -------------------
module icache_ctrl (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                cache_enable_i,
    input  logic                                paddr_is_nc_i,
    input  logic                                flush_i,
    input  logic                                flush_done_i,
    input  logic                                req_pending_i,
    input  logic [icache_pkg::ICACHE_N_WAY-1:0] cline_hit_i,
    input  logic                                ireq_kill_i,
    input  logic                                ifill_resp_valid_i,
    output logic                                cmp_enable_o,
    output logic                                cache_wr_ena_o,
    output logic                                fill_capture_o,
    output logic                                replay_valid_o,
    output logic                                flush_en_o,
    output logic                                iresp_ready_o,
    output logic                                iresp_valid_o,
    output logic                                ifill_req_valid_o,
    output logic                                miss_o,
    output logic                                miss_kill_o
);
    import icache_pkg::*;

    ictrl_state_t state_q;
    ictrl_state_t state_d;
    logic         is_hit;
    logic         new_miss;

    assign is_hit   = |cline_hit_i;
    assign new_miss = req_pending_i && !is_hit && !ireq_kill_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= READ;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d           = state_q;
        cmp_enable_o      = 1'b0;
        cache_wr_ena_o    = 1'b0;
        fill_capture_o    = 1'b0;
        replay_valid_o    = 1'b0;
        flush_en_o        = 1'b0;
        iresp_ready_o     = 1'b0;
        iresp_valid_o     = 1'b0;
        ifill_req_valid_o = 1'b0;
        miss_o            = 1'b0;
        miss_kill_o       = 1'b0;
        case (state_q)
            READ: begin
                cmp_enable_o      = cache_enable_i;
                iresp_valid_o     = req_pending_i && is_hit && !ireq_kill_i;
                ifill_req_valid_o = new_miss;
                miss_o            = new_miss;                  // One pulse per miss.
                iresp_ready_o     = !flush_i && !new_miss;
                if (new_miss) begin
                    state_d = MISS;
                end else if (flush_i && !req_pending_i) begin
                    state_d = FLUSH;                           // Nothing left in flight.
                end
            end
            MISS: begin
                // Line is captured in the arrival cycle and installed if cacheable
                fill_capture_o = ifill_resp_valid_i;
                cache_wr_ena_o = ifill_resp_valid_i && !ireq_kill_i && cache_enable_i
                                 && !paddr_is_nc_i;
                miss_kill_o    = ireq_kill_i;
                if (ireq_kill_i) begin
                    state_d = ifill_resp_valid_i ? READ : KILL;
                end else if (ifill_resp_valid_i) begin
                    state_d = REPLAY;
                end
            end
            REPLAY: begin
                replay_valid_o = 1'b1;                         // Word from fill buffer.
                iresp_valid_o  = 1'b1;
                state_d        = READ;
            end
            KILL: begin
                if (ifill_resp_valid_i) begin
                    state_d = READ;                            // Fill data is dropped.
                end
            end
            FLUSH: begin
                flush_en_o = 1'b1;
                if (flush_done_i) begin
                    state_d = READ;
                end
            end
            default: begin
                state_d = READ;
            end
        endcase
    end

endmodule

// File: rtl/icache_csr.sv
// -------------------
// Configuration registers: cache enable, flush command and
// status, and the saturating PMU miss and kill-miss counters.
// -------------------
module icache_csr (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          cfg_we_i,
    input  logic [1:0]                    cfg_addr_i,
    input  logic [icache_pkg::WORD_W-1:0] cfg_wdata_i,
    output logic [icache_pkg::WORD_W-1:0] cfg_rdata_o,
    input  logic                          miss_i,
    input  logic                          miss_kill_i,
    input  logic                          flush_en_i,
    output logic                          cache_enable_o,
    output logic                          flush_req_o
);
    import icache_pkg::*;

    logic             enable_q;
    logic             flush_req_q;
    logic [CNT_W-1:0] cnt_q [2];                        // Miss, then kill-miss.
    logic [1:0]       cnt_inc;
    logic [1:0]       cnt_clr;

    assign cnt_inc = {miss_kill_i, miss_i};
    assign cnt_clr = {cfg_we_i && (cfg_addr_i == CSR_KILL_CNT),
                      cfg_we_i && (cfg_addr_i == CSR_MISS_CNT)};

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            enable_q    <= 1'b0;
            flush_req_q <= 1'b0;
            cnt_q       <= '{default: '0};
        end else begin
            if (cfg_we_i && (cfg_addr_i == CSR_CTRL)) begin
                enable_q <= cfg_wdata_i[0];
            end
            if (cfg_we_i && (cfg_addr_i == CSR_CTRL) && cfg_wdata_i[1]) begin
                flush_req_q <= 1'b1;
            end else if (flush_en_i) begin
                flush_req_q <= 1'b0;                    // Controller took it.
            end
            for (int i = 0; i < 2; i++) begin
                if (cnt_clr[i]) begin
                    cnt_q[i] <= '0;
                end else if (cnt_inc[i] && (cnt_q[i] != '1)) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (cfg_addr_i)
            CSR_CTRL:     cfg_rdata_o = WORD_W'(enable_q);     // Flush bit reads 0.
            CSR_STATUS:   cfg_rdata_o = WORD_W'(flush_req_q || flush_en_i);
            CSR_MISS_CNT: cfg_rdata_o = WORD_W'(cnt_q[0]);
            default:      cfg_rdata_o = WORD_W'(cnt_q[1]);
        endcase
    end

    assign cache_enable_o = enable_q;
    assign flush_req_o    = flush_req_q;

endmodule

// File: rtl/icache_top.sv
// -------------------
// Instruction cache top level. Connects lookup, way RAMs,
// controller and configuration block to the core, the upper
// memory and the register port.
// -------------------
module icache_top (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          ireq_valid_i,
    input  logic [icache_pkg::ADDR_W-1:0] ireq_addr_i,
    input  logic                          ireq_kill_i,
    output logic                          iresp_ready_o,
    output logic                          iresp_valid_o,
    output logic [icache_pkg::WORD_W-1:0] iresp_data_o,
    output logic                          ifill_req_valid_o,
    output logic [icache_pkg::ADDR_W-1:0] ifill_addr_o,
    input  logic                          ifill_resp_valid_i,
    input  logic [icache_pkg::LINE_W-1:0] ifill_resp_data_i,
    input  logic                          cfg_we_i,
    input  logic [1:0]                    cfg_addr_i,
    input  logic [icache_pkg::WORD_W-1:0] cfg_wdata_i,
    output logic [icache_pkg::WORD_W-1:0] cfg_rdata_o
);
    import icache_pkg::*;

    tag_entry_t              tag_rdata [ICACHE_N_WAY];
    line_entry_t             line_rdata [ICACHE_N_WAY];
    tag_entry_t              tag_wdata;
    line_entry_t             line_wdata;
    logic                    ram_rd_en;
    logic [ICACHE_N_WAY-1:0] ram_wr_en;
    logic [INDEX_W-1:0]      ram_index;
    logic                    req_pending;
    logic [ICACHE_N_WAY-1:0] cline_hit;
    logic                    paddr_is_nc;
    logic                    flush_done;
    logic                    cmp_enable;
    logic                    cache_wr_ena;
    logic                    fill_capture;
    logic                    replay_valid;
    logic                    flush_en;
    logic                    miss_pulse;
    logic                    miss_kill_pulse;
    logic                    cache_enable;
    logic                    flush_req;

    icache_lookup u_lookup (
        .clk_i, .rstn_i, .ireq_valid_i, .ireq_addr_i,
        .cache_enable_i   (cache_enable),
        .cmp_enable_i     (cmp_enable),
        .cache_wr_ena_i   (cache_wr_ena),
        .fill_capture_i   (fill_capture),
        .replay_valid_i   (replay_valid),
        .flush_en_i       (flush_en),
        .ifill_resp_data_i,
        .tag_rdata_i      (tag_rdata),
        .line_rdata_i     (line_rdata),
        .ram_rd_en_o      (ram_rd_en),
        .ram_wr_en_o      (ram_wr_en),
        .ram_index_o      (ram_index),
        .tag_wdata_o      (tag_wdata),
        .line_wdata_o     (line_wdata),
        .req_pending_o    (req_pending),
        .cline_hit_o      (cline_hit),
        .paddr_is_nc_o    (paddr_is_nc),
        .flush_done_o     (flush_done),
        .ifill_addr_o, .iresp_data_o
    );

    // Tag and line RAM pair per way
    for (genvar w = 0; w < ICACHE_N_WAY; w++) begin : g_way
        icache_way_ram #(.entry_t(tag_entry_t)) u_tag_ram (
            .clk_i, .rd_en_i(ram_rd_en), .wr_en_i(ram_wr_en[w]), .index_i(ram_index),
            .wdata_i(tag_wdata), .rdata_o(tag_rdata[w])
        );
        icache_way_ram #(.entry_t(line_entry_t)) u_line_ram (
            .clk_i, .rd_en_i(ram_rd_en), .wr_en_i(ram_wr_en[w]), .index_i(ram_index),
            .wdata_i(line_wdata), .rdata_o(line_rdata[w])
        );
    end

    icache_ctrl u_ctrl (
        .clk_i, .rstn_i,
        .cache_enable_i   (cache_enable),
        .paddr_is_nc_i    (paddr_is_nc),
        .flush_i          (flush_req),
        .flush_done_i     (flush_done),
        .req_pending_i    (req_pending),
        .cline_hit_i      (cline_hit),
        .ireq_kill_i, .ifill_resp_valid_i,
        .cmp_enable_o     (cmp_enable),
        .cache_wr_ena_o   (cache_wr_ena),
        .fill_capture_o   (fill_capture),
        .replay_valid_o   (replay_valid),
        .flush_en_o       (flush_en),
        .iresp_ready_o, .iresp_valid_o, .ifill_req_valid_o,
        .miss_o           (miss_pulse),
        .miss_kill_o      (miss_kill_pulse)
    );

    icache_csr u_csr (
        .clk_i, .rstn_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
        .miss_i           (miss_pulse),
        .miss_kill_i      (miss_kill_pulse),
        .flush_en_i       (flush_en),
        .cache_enable_o   (cache_enable),
        .flush_req_o      (flush_req)
    );

endmodule

// File: verif/icache_checker.sv
// -------------------
// Reference model and scoreboard for the instruction cache.
// Watches the DUT ports every rising edge, mirrors tags, valid
// bits and victims, and checks responses, fills and registers.
// -------------------
module icache_checker (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          ireq_valid_i,
    input  logic [icache_pkg::ADDR_W-1:0] ireq_addr_i,
    input  logic                          ireq_kill_i,
    input  logic                          iresp_ready_o,
    input  logic                          iresp_valid_o,
    input  logic [icache_pkg::WORD_W-1:0] iresp_data_o,
    input  logic                          ifill_req_valid_o,
    input  logic [icache_pkg::ADDR_W-1:0] ifill_addr_o,
    input  logic                          ifill_resp_valid_i,
    input  logic                          cfg_we_i,
    input  logic [1:0]                    cfg_addr_i,
    input  logic [icache_pkg::WORD_W-1:0] cfg_wdata_i,
    input  logic [icache_pkg::WORD_W-1:0] cfg_rdata_o,
    input  logic                          rd_chk_i,
    input  logic                          test_done_i,
    input  logic [2:0]                    test_id_i,
    output int                            err_cnt_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import icache_pkg::*;

    tag_entry_t  tag_m [ICACHE_N_SET][ICACHE_N_WAY];
    logic        valid_m [ICACHE_N_SET][ICACHE_N_WAY];
    logic        victim_m [ICACHE_N_SET];
    logic        enable_m;
    logic        flush_busy;
    int          flush_left;                             // Cycles until back in READ.
    logic        cmp_busy;                               // Request in compare stage.
    logic [31:0] cmp_addr;
    logic        miss_busy;
    logic        miss_killed;
    logic        miss_install;
    logic [31:0] miss_addr;
    logic        replay_due;
    int          miss_cnt;
    int          kill_cnt;
    int          errors = 0;
    int          last_errors = 0;
    string       names [6] = '{"hits", "misses", "uncached", "kills", "flush", "counters"};

    assign err_cnt_o = errors;

    // Upper memory rule for the word at a byte address.
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5A5A_0000;
    endfunction

    task automatic report(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        errors++;
    endtask

    always @(posedge clk_i) begin : model
        logic              exp_valid;
        logic              exp_fill;
        logic              exp_ready;
        logic              idle;
        logic [31:0]       exp_data;
        logic [31:0]       exp_rd;
        logic              hit;
        logic [INDEX_W-1:0] idx;
        int                way;
        if (!rstn_i) begin
            valid_m    = '{default: '0};
            victim_m   = '{default: '0};
            enable_m   = 1'b0;
            flush_busy = 1'b0;
            flush_left = 0;
            cmp_busy   = 1'b0;
            miss_busy  = 1'b0;
            replay_due = 1'b0;
            miss_cnt   = 0;
            kill_cnt   = 0;
        end else begin
            exp_valid = 1'b0;
            exp_fill  = 1'b0;
            exp_data  = '0;
            idle      = !cmp_busy && !miss_busy && !replay_due;
            exp_ready = !miss_busy && !replay_due && !flush_busy;
            if (replay_due) begin
                exp_valid  = 1'b1;
                exp_data   = mem_word(miss_addr);
                replay_due = 1'b0;
            end
            if (miss_busy) begin
                if (ireq_kill_i && !miss_killed) begin
                    miss_killed = 1'b1;
                    kill_cnt++;
                end
                if (ifill_resp_valid_i) begin
                    miss_busy = 1'b0;
                    if (!miss_killed) begin
                        replay_due = 1'b1;                // Answer in the next cycle.
                        if (miss_install) begin
                            idx                = miss_addr[7:4];
                            way                = int'(victim_m[idx]);
                            valid_m[idx][way]  = 1'b1;
                            tag_m[idx][way]    = miss_addr[31:8];
                            victim_m[idx]      = ~victim_m[idx];
                        end
                    end
                end
            end
            if (cmp_busy) begin
                cmp_busy = 1'b0;
                if (!ireq_kill_i) begin
                    idx = cmp_addr[7:4];
                    hit = 1'b0;
                    for (int w = 0; w < ICACHE_N_WAY; w++) begin
                        if (enable_m && !cmp_addr[NC_BIT] && valid_m[idx][w]
                            && tag_m[idx][w] == cmp_addr[31:8]) begin
                            hit = 1'b1;
                        end
                    end
                    if (hit) begin
                        exp_valid = 1'b1;
                        exp_data  = mem_word(cmp_addr);
                    end else begin
                        exp_fill     = 1'b1;
                        exp_ready    = 1'b0;              // Miss stalls the core.
                        miss_busy    = 1'b1;
                        miss_killed  = 1'b0;
                        miss_install = enable_m && !cmp_addr[NC_BIT];
                        miss_addr    = cmp_addr;
                        miss_cnt++;
                    end
                end
            end
            if (exp_valid && iresp_valid_o !== 1'b1) begin
                $display("response missing at time %0t", $time);
                errors++;
            end else if (!exp_valid && iresp_valid_o !== 1'b0) begin
                report("unexpected response");
            end else if (exp_valid && iresp_data_o !== exp_data) begin
                report($sformatf("data %h, expected %h", iresp_data_o, exp_data));
            end
            if (ifill_req_valid_o !== exp_fill) begin
                report($sformatf("fill request %b, expected %b", ifill_req_valid_o, exp_fill));
            end else if (exp_fill && ifill_addr_o !== {cmp_addr[31:4], 4'h0}) begin
                report($sformatf("fill address %h for request %h", ifill_addr_o, cmp_addr));
            end
            if (iresp_ready_o !== exp_ready) begin
                report($sformatf("ready %b, expected %b", iresp_ready_o, exp_ready));
            end
            if (ireq_valid_i && exp_ready) begin
                cmp_busy = 1'b1;
                cmp_addr = ireq_addr_i;
            end
            if (rd_chk_i) begin
                case (cfg_addr_i)
                    CSR_CTRL:     exp_rd = 32'(enable_m);
                    CSR_STATUS:   exp_rd = 32'(flush_busy);
                    CSR_MISS_CNT: exp_rd = 32'(miss_cnt);
                    default:      exp_rd = 32'(kill_cnt);
                endcase
                if (cfg_rdata_o !== exp_rd) begin
                    report($sformatf("register %0d reads %0d, expected %0d",
                                     cfg_addr_i, cfg_rdata_o, exp_rd));
                end
            end
            // One idle READ cycle, then one set per cycle
            if (flush_busy && idle) begin
                flush_left--;
                if (flush_left == 0) begin
                    flush_busy = 1'b0;                    // Back in READ.
                end
            end
            if (cfg_we_i) begin
                case (cfg_addr_i)
                    CSR_CTRL: begin
                        enable_m = cfg_wdata_i[0];
                        if (cfg_wdata_i[1]) begin
                            valid_m    = '{default: '0};
                            victim_m   = '{default: '0};
                            flush_busy = 1'b1;
                            flush_left = ICACHE_N_SET + 1;
                        end
                    end
                    CSR_MISS_CNT: miss_cnt = 0;
                    CSR_KILL_CNT: kill_cnt = 0;
                    default: ;
                endcase
            end
            if (test_done_i) begin
                $display("test %0d %s finished with %0d errors", test_id_i,
                         names[test_id_i], errors - last_errors);
                last_errors = errors;
            end
        end
    end

endmodule

// File: verif/icache_tb.sv
// -------------------
// Testbench top for the instruction cache. Drives seeded random
// fetches, kills, flushes and register accesses, models the
// upper memory and bounds the run with a cycle limit.
// -------------------
module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import icache_pkg::*;

    localparam int N_SLOTS    = 400;
    localparam int MAX_CYCLES = N_SLOTS * 12 + 200;

    logic                clk_i;
    logic                rstn_i;
    logic                ireq_valid_i;
    logic [ADDR_W-1:0]   ireq_addr_i;
    logic                ireq_kill_i;
    logic                iresp_ready_o;
    logic                iresp_valid_o;
    logic [WORD_W-1:0]   iresp_data_o;
    logic                ifill_req_valid_o;
    logic [ADDR_W-1:0]   ifill_addr_o;
    logic                ifill_resp_valid_i;
    logic [LINE_W-1:0]   ifill_resp_data_i;
    logic                cfg_we_i;
    logic [1:0]          cfg_addr_i;
    logic [WORD_W-1:0]   cfg_wdata_i;
    logic [WORD_W-1:0]   cfg_rdata_o;
    logic                rd_chk;
    logic                test_done;
    logic [2:0]          test_id;
    int                  err_cnt;
    int                  cycles = 0;

    icache_top dut (.*);

    icache_checker chk (
        .*,
        .rd_chk_i    (rd_chk),
        .test_done_i (test_done),
        .test_id_i   (test_id),
        .err_cnt_o   (err_cnt)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // Upper memory answers each fill after 2 to 9 cycles.
    always @(posedge clk_i) begin : responder
        logic [ADDR_W-1:0] a;
        int                delay;
        if (rstn_i && ifill_req_valid_o) begin
            a     = ifill_addr_o;
            delay = 2 + int'($urandom % 8);
            repeat (delay - 1) @(posedge clk_i);
            #2;
            ifill_resp_valid_i = 1'b1;
            for (int i = 0; i < 4; i++) begin
                ifill_resp_data_i[i*32 +: 32] = (a + 32'(4 * i)) ^ 32'h5A5A_0000;
            end
            @(posedge clk_i);
            #2;
            ifill_resp_valid_i = 1'b0;
        end
    end

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic send(input logic [31:0] a);
        while (!iresp_ready_o) next_cycle();
        ireq_valid_i = 1'b1;
        ireq_addr_i  = a;
        next_cycle();
        ireq_valid_i = 1'b0;
    endtask

    task automatic settle();
        next_cycle();
        while (!iresp_ready_o) next_cycle();
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        settle();
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        next_cycle();
        cfg_we_i = 1'b0;
    endtask

    task automatic cfg_check(input logic [1:0] addr);
        cfg_addr_i = addr;
        rd_chk     = 1'b1;
        next_cycle();
        rd_chk = 1'b0;
    endtask

    task automatic end_test(input logic [2:0] id);
        settle();
        cfg_check(CSR_MISS_CNT);
        cfg_check(CSR_KILL_CNT);
        test_id   = id;
        test_done = 1'b1;
        next_cycle();
        test_done = 1'b0;
    endtask

    // Pool of lines over four sets, two tags per set for every 8 lines.
    function automatic logic [31:0] rand_addr(input int pool, input bit nc_ok);
        int          k;
        logic [31:0] a;
        k = int'($urandom % pool);
        a = 32'h0002_0000 + 32'((k / 4) << 8) + 32'((k % 4) << 4) + 32'(($urandom % 4) << 2);
        if (nc_ok && ($urandom % 8 == 0)) begin
            a[NC_BIT] = 1'b1;
        end
        return a;
    endfunction

    initial begin
        void'($urandom(5));
        clk_i = 1'b0;
        rstn_i = 1'b0;
        ireq_valid_i = 1'b0;
        ireq_addr_i = '0;
        ireq_kill_i = 1'b0;
        ifill_resp_valid_i = 1'b0;
        ifill_resp_data_i = '0;
        cfg_we_i = 1'b0;
        cfg_addr_i = '0;
        cfg_wdata_i = '0;
        rd_chk = 1'b0;
        test_done = 1'b0;
        test_id = '0;
        repeat (4) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;

        cfg_write(CSR_CTRL, 32'd1);
        repeat (60) send(rand_addr(8, 1'b0));
        end_test(3'd0);

        repeat (80) send(rand_addr(24, 1'b1));
        end_test(3'd1);

        cfg_write(CSR_CTRL, 32'd0);                      // Cache off.
        repeat (30) send(rand_addr(8, 1'b0));
        cfg_write(CSR_CTRL, 32'd1);
        repeat (30) send(rand_addr(8, 1'b0) | 32'h8000_0000);
        end_test(3'd2);

        repeat (40) begin
            case ($urandom % 3)
                0: begin
                    send(rand_addr(8, 1'b0));
                    ireq_kill_i = 1'b1;                  // Compare-stage kill.
                    next_cycle();
                    ireq_kill_i = 1'b0;
                end
                1: begin
                    send(rand_addr(24, 1'b0));
                    if (!iresp_ready_o) begin
                        next_cycle();
                        ireq_kill_i = 1'b1;              // Kill while in MISS.
                        next_cycle();
                        ireq_kill_i = 1'b0;
                    end
                end
                default: send(rand_addr(8, 1'b0));
            endcase
        end
        end_test(3'd3);

        cfg_write(CSR_CTRL, 32'd3);
        cfg_check(CSR_STATUS);
        settle();
        cfg_check(CSR_STATUS);
        repeat (40) send(rand_addr(8, 1'b1));
        end_test(3'd4);

        cfg_write(CSR_MISS_CNT, 32'd0);
        cfg_write(CSR_KILL_CNT, 32'd0);
        end_test(3'd5);

        $display("6 tests run, %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: icache_top.f
rtl/icache_pkg.sv
rtl/icache_way_ram.sv
rtl/icache_lookup.sv
rtl/icache_ctrl.sv
rtl/icache_csr.sv
rtl/icache_top.sv
verif/icache_checker.sv
verif/icache_tb.sv

// File: Makefile
SIM      := verilator
TOP      := icache_tb
FILELIST := icache_top.f
FLAGS    := --binary --timing -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := all tests passed
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
